// File: source/dma_consts.svh
`ifndef DMA_CONSTS_SVH
`define DMA_CONSTS_SVH

// bus widths
`define DMA_ADDR_W 16
`define DMA_DATA_W 8

// register map of the cpu i/o space
`define DMA_REG_OAM   16'hFF46
`define DMA_REG_HDMA1 16'hFF51
`define DMA_REG_HDMA2 16'hFF52
`define DMA_REG_HDMA3 16'hFF53
`define DMA_REG_HDMA4 16'hFF54
`define DMA_REG_HDMA5 16'hFF55

// oam copy, fixed page and length
`define DMA_OAM_PAGE 8'hFE
`define DMA_OAM_LEN  160

// video ram copies
`define DMA_VRAM_TOP  3'b100
`define DMA_BLOCK_LEN 16

`endif

// File: source/dma_pkg.sv
`include "dma_consts.svh"

package dma_pkg;

   // field view of the hdma5 control byte
   typedef struct packed {
      logic                    hblank_mode;   // 1 selects hblank dma
      logic [`DMA_DATA_W-2:0]  block_count;   // blocks minus one
   } hdma5_ctrl_s;

   // same byte seen raw for storage and read-back, or split into fields
   typedef union packed {
      logic [`DMA_DATA_W-1:0]  raw;
      hdma5_ctrl_s             ctrl;
   } hdma5_word_u;

endpackage

// File: source/dma_io_regs.sv
`timescale 1ns/1ps
`include "dma_consts.svh"

module dma_io_regs (
   input  logic                     I_CLK,
   input  logic                     I_SYNC_RESET,
   input  logic [`DMA_ADDR_W-1:0]   ioreg_addr,
   input  logic [`DMA_DATA_W-1:0]   ioreg_wdata,
   input  logic                     ioreg_we_l,
   input  logic                     ioreg_re_l,
   output logic [`DMA_DATA_W-1:0]   ioreg_rdata,
   input  logic                     vram_busy,
   output logic [`DMA_DATA_W-1:0]   oam_src_page,
   output logic [`DMA_DATA_W-1:0]   hdma_src_high,
   output logic [`DMA_DATA_W-1:0]   hdma_src_low,
   output logic [`DMA_DATA_W-1:0]   hdma_dst_high,
   output logic [`DMA_DATA_W-1:0]   hdma_dst_low,
   output dma_pkg::hdma5_word_u     hdma5_ctrl,
   output logic                     oam_start,
   output logic                     hdma5_write
);

   dma_pkg::hdma5_word_u hdma5_status;   // what a read of ff55 returns

   // register storage, written on the edge where the strobe is low
   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         oam_src_page   <= '0;
         hdma_src_high  <= '0;
         hdma_src_low   <= '0;
         hdma_dst_high  <= '0;
         hdma_dst_low   <= '0;
         hdma5_ctrl.raw <= '0;
      end else if (!ioreg_we_l) begin
         case (ioreg_addr)
            `DMA_REG_OAM:   oam_src_page   <= ioreg_wdata;
            `DMA_REG_HDMA1: hdma_src_high  <= ioreg_wdata;
            `DMA_REG_HDMA2: hdma_src_low   <= ioreg_wdata;
            `DMA_REG_HDMA3: hdma_dst_high  <= ioreg_wdata;
            `DMA_REG_HDMA4: hdma_dst_low   <= ioreg_wdata;
            `DMA_REG_HDMA5: hdma5_ctrl.raw <= ioreg_wdata;
            default: ;
         endcase
      end
   end

   // start pulses, one cycle after the write lands
   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         oam_start   <= 1'b0;
         hdma5_write <= 1'b0;
      end else begin
         oam_start   <= !ioreg_we_l && (ioreg_addr == `DMA_REG_OAM);
         hdma5_write <= !ioreg_we_l && (ioreg_addr == `DMA_REG_HDMA5);
      end
   end

   // ff55 reads as status, not as the stored control byte
   always_comb begin
      hdma5_status.raw              = '0;
      hdma5_status.ctrl.hblank_mode = vram_busy;   // busy in bit 7
   end

   always_comb begin
      ioreg_rdata = '0;
      if (!ioreg_re_l) begin
         case (ioreg_addr)
            `DMA_REG_OAM:   ioreg_rdata = oam_src_page;
            `DMA_REG_HDMA1: ioreg_rdata = hdma_src_high;
            `DMA_REG_HDMA2: ioreg_rdata = hdma_src_low;
            `DMA_REG_HDMA3: ioreg_rdata = hdma_dst_high;
            `DMA_REG_HDMA4: ioreg_rdata = hdma_dst_low;
            `DMA_REG_HDMA5: ioreg_rdata = hdma5_status.raw;
            default:        ioreg_rdata = '0;   // unmapped
         endcase
      end
   end

endmodule

// File: source/oam_dma_engine.sv
`timescale 1ns/1ps
`include "dma_consts.svh"

module oam_dma_engine (
   input  logic                     I_CLK,
   input  logic                     I_SYNC_RESET,
   input  logic                     oam_start,
   input  logic [`DMA_DATA_W-1:0]   oam_src_page,
   output logic                     oam_active,
   output logic [`DMA_ADDR_W-1:0]   oam_rd_addr,
   output logic [`DMA_ADDR_W-1:0]   oam_wr_addr,
   output logic                     oam_strobe_l
);

   localparam logic OAM_IDLE = 1'b0;
   localparam logic OAM_COPY = 1'b1;

   localparam logic [`DMA_DATA_W-1:0] OAM_LAST = `DMA_DATA_W'(`DMA_OAM_LEN - 1);

   logic                    oam_state;
   logic [`DMA_DATA_W-1:0]  oam_count;   // byte offset, low half of both addresses

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         oam_state <= OAM_IDLE;
         oam_count <= '0;
      end else begin
         case (oam_state)
            OAM_IDLE: begin
               if (oam_start) begin
                  oam_state <= OAM_COPY;
                  oam_count <= '0;
               end
            end
            OAM_COPY: begin
               if (oam_count == OAM_LAST) begin   // byte 159 moves this cycle
                  oam_state <= OAM_IDLE;
                  oam_count <= '0;
               end else begin
                  oam_count <= oam_count + `DMA_DATA_W'(1);
               end
            end
            default: begin
               oam_state <= OAM_IDLE;
            end
         endcase
      end
   end

   // every cycle in copy is one byte moved
   assign oam_active   = (oam_state == OAM_COPY);
   assign oam_strobe_l = !oam_active;

   assign oam_rd_addr = {oam_src_page, oam_count};
   assign oam_wr_addr = {`DMA_OAM_PAGE, oam_count};   // sprite table at fe00

endmodule

// File: source/vram_dma_engine.sv
`timescale 1ns/1ps
`include "dma_consts.svh"

module vram_dma_engine (
   input  logic                     I_CLK,
   input  logic                     I_SYNC_RESET,
   input  logic                     I_HBLANK,
   input  logic                     hdma5_write,
   input  dma_pkg::hdma5_word_u     hdma5_ctrl,
   input  logic [`DMA_DATA_W-1:0]   hdma_src_high,
   input  logic [`DMA_DATA_W-1:0]   hdma_src_low,
   input  logic [`DMA_DATA_W-1:0]   hdma_dst_high,
   input  logic [`DMA_DATA_W-1:0]   hdma_dst_low,
   output logic                     vram_active,
   output logic [`DMA_ADDR_W-1:0]   vram_rd_addr,
   output logic [`DMA_ADDR_W-1:0]   vram_wr_addr,
   output logic                     vram_strobe_l,
   output logic                     vram_busy
);

   localparam logic [2:0] VRAM_IDLE        = 3'd0;
   localparam logic [2:0] VRAM_GEN_RUN     = 3'd1;
   localparam logic [2:0] VRAM_WAIT_BLANK  = 3'd2;
   localparam logic [2:0] VRAM_BLOCK_WRITE = 3'd3;
   localparam logic [2:0] VRAM_BLOCK_PAUSE = 3'd4;

   localparam int BLOCK_LAST = `DMA_BLOCK_LEN - 1;

   logic [2:0]              vram_state;
   logic [`DMA_ADDR_W-1:0]  vram_count;   // offset shared by both bases
   logic [`DMA_ADDR_W-1:0]  src_base;
   logic [`DMA_ADDR_W-1:0]  dst_base;
   logic [`DMA_ADDR_W-1:0]  xfer_last;    // offset of the final byte
   logic                    block_end;
   logic                    xfer_end;
   logic                    cancel_req;
   logic                    hblank_d1;
   logic                    hblank_rise;

   // both bases aligned to 16 bytes, destination forced into 8000-9ff0
   assign src_base = {hdma_src_high, hdma_src_low[7:4], 4'b0000};
   assign dst_base = {`DMA_VRAM_TOP, hdma_dst_high[4:0], hdma_dst_low[7:4], 4'b0000};

   // 16*(n+1)-1, the low nibble of the last offset is always f
   assign xfer_last = {{(`DMA_ADDR_W - 11){1'b0}},
                       hdma5_ctrl.ctrl.block_count,
                       BLOCK_LAST[3:0]};

   assign block_end  = (vram_count[3:0] == BLOCK_LAST[3:0]);
   assign xfer_end   = (vram_count == xfer_last);
   assign cancel_req = hdma5_write && !hdma5_ctrl.ctrl.hblank_mode;

   assign vram_rd_addr = src_base + vram_count;
   assign vram_wr_addr = dst_base + vram_count;

   // blanking rise, seen by the fsm two cycles after the input edge
   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         hblank_d1   <= 1'b0;
         hblank_rise <= 1'b0;
      end else begin
         hblank_d1   <= I_HBLANK;
         hblank_rise <= I_HBLANK && !hblank_d1;
      end
   end

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         vram_state <= VRAM_IDLE;
         vram_count <= '0;
      end else begin
         case (vram_state)
            VRAM_IDLE: begin
               vram_count <= '0;
               if (hdma5_write) begin
                  if (hdma5_ctrl.ctrl.hblank_mode) begin
                     vram_state <= VRAM_WAIT_BLANK;
                  end else begin
                     vram_state <= VRAM_GEN_RUN;
                  end
               end
            end
            VRAM_GEN_RUN: begin
               if (xfer_end) begin
                  vram_state <= VRAM_IDLE;
                  vram_count <= '0;
               end else begin
                  vram_count <= vram_count + `DMA_ADDR_W'(1);
               end
            end
            VRAM_WAIT_BLANK: begin
               if (cancel_req) begin
                  vram_state <= VRAM_IDLE;
               end else if (hblank_rise) begin
                  vram_state <= VRAM_BLOCK_WRITE;
               end
            end
            VRAM_BLOCK_WRITE: begin
               if (cancel_req || xfer_end) begin
                  vram_state <= VRAM_IDLE;
                  vram_count <= '0;
               end else if (block_end) begin   // 16th byte of this burst
                  vram_state <= VRAM_BLOCK_PAUSE;
                  vram_count <= vram_count + `DMA_ADDR_W'(1);
               end else begin
                  vram_count <= vram_count + `DMA_ADDR_W'(1);
               end
            end
            VRAM_BLOCK_PAUSE: begin
               if (cancel_req) begin
                  vram_state <= VRAM_IDLE;
                  vram_count <= '0;
               end else if (hblank_rise) begin
                  vram_state <= VRAM_BLOCK_WRITE;   // count carries on
               end
            end
            default: begin
               vram_state <= VRAM_IDLE;
            end
         endcase
      end
   end

   // port is requested only in cycles that move a byte
   assign vram_active   = (vram_state == VRAM_GEN_RUN) || (vram_state == VRAM_BLOCK_WRITE);
   assign vram_strobe_l = !vram_active;

   // pending and paused hblank transfers also count as busy
   assign vram_busy = (vram_state != VRAM_IDLE);

endmodule

// File: source/dma_port_arbiter.sv
`timescale 1ns/1ps
`include "dma_consts.svh"

module dma_port_arbiter (
   input  logic                     oam_active,
   input  logic [`DMA_ADDR_W-1:0]   oam_rd_addr,
   input  logic [`DMA_ADDR_W-1:0]   oam_wr_addr,
   input  logic                     oam_strobe_l,
   input  logic                     vram_active,
   input  logic [`DMA_ADDR_W-1:0]   vram_rd_addr,
   input  logic [`DMA_ADDR_W-1:0]   vram_wr_addr,
   input  logic                     vram_strobe_l,
   output logic [`DMA_ADDR_W-1:0]   rdma_addr,
   output logic                     rdma_re_l,
   output logic [`DMA_ADDR_W-1:0]   wdma_addr,
   output logic                     wdma_we_l
);

   // oam wins over video ram, one strobe drives both sides
   always_comb begin
      if (oam_active) begin
         rdma_addr = oam_rd_addr;
         wdma_addr = oam_wr_addr;
         rdma_re_l = oam_strobe_l;
         wdma_we_l = oam_strobe_l;
      end else if (vram_active) begin
         rdma_addr = vram_rd_addr;
         wdma_addr = vram_wr_addr;
         rdma_re_l = vram_strobe_l;
         wdma_we_l = vram_strobe_l;
      end else begin
         rdma_addr = '0;   // idle port
         wdma_addr = '0;
         rdma_re_l = 1'b1;
         wdma_we_l = 1'b1;
      end
   end

endmodule

// File: source/dma_controller.sv
`timescale 1ns/1ps
`include "dma_consts.svh"

module dma_controller (
   input  logic                     I_CLK,
   input  logic                     I_SYNC_RESET,
   input  logic                     I_HBLANK,
   input  logic [`DMA_ADDR_W-1:0]   ioreg_addr,
   input  logic [`DMA_DATA_W-1:0]   ioreg_wdata,
   input  logic                     ioreg_we_l,
   input  logic                     ioreg_re_l,
   output logic [`DMA_DATA_W-1:0]   ioreg_rdata,
   output logic [`DMA_ADDR_W-1:0]   rdma_addr,
   output logic                     rdma_re_l,
   input  logic [`DMA_DATA_W-1:0]   rdma_data,
   output logic [`DMA_ADDR_W-1:0]   wdma_addr,
   output logic                     wdma_we_l,
   output logic [`DMA_DATA_W-1:0]   wdma_data
);

   logic [`DMA_DATA_W-1:0]  oam_src_page;
   logic [`DMA_DATA_W-1:0]  hdma_src_high;
   logic [`DMA_DATA_W-1:0]  hdma_src_low;
   logic [`DMA_DATA_W-1:0]  hdma_dst_high;
   logic [`DMA_DATA_W-1:0]  hdma_dst_low;
   dma_pkg::hdma5_word_u    hdma5_ctrl;
   logic                    oam_start;
   logic                    hdma5_write;
   logic                    vram_busy;
   logic                    oam_active;
   logic [`DMA_ADDR_W-1:0]  oam_rd_addr;
   logic [`DMA_ADDR_W-1:0]  oam_wr_addr;
   logic                    oam_strobe_l;
   logic                    vram_active;
   logic [`DMA_ADDR_W-1:0]  vram_rd_addr;
   logic [`DMA_ADDR_W-1:0]  vram_wr_addr;
   logic                    vram_strobe_l;

   // memory answers in the same cycle, so the byte goes straight through
   assign wdma_data = rdma_data;

   dma_io_regs u_io_regs (
      .I_CLK         (I_CLK),
      .I_SYNC_RESET  (I_SYNC_RESET),
      .ioreg_addr    (ioreg_addr),
      .ioreg_wdata   (ioreg_wdata),
      .ioreg_we_l    (ioreg_we_l),
      .ioreg_re_l    (ioreg_re_l),
      .ioreg_rdata   (ioreg_rdata),
      .vram_busy     (vram_busy),
      .oam_src_page  (oam_src_page),
      .hdma_src_high (hdma_src_high),
      .hdma_src_low  (hdma_src_low),
      .hdma_dst_high (hdma_dst_high),
      .hdma_dst_low  (hdma_dst_low),
      .hdma5_ctrl    (hdma5_ctrl),
      .oam_start     (oam_start),
      .hdma5_write   (hdma5_write)
   );

   oam_dma_engine u_oam_dma (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .oam_start    (oam_start),
      .oam_src_page (oam_src_page),
      .oam_active   (oam_active),
      .oam_rd_addr  (oam_rd_addr),
      .oam_wr_addr  (oam_wr_addr),
      .oam_strobe_l (oam_strobe_l)
   );

   vram_dma_engine u_vram_dma (
      .I_CLK         (I_CLK),
      .I_SYNC_RESET  (I_SYNC_RESET),
      .I_HBLANK      (I_HBLANK),
      .hdma5_write   (hdma5_write),
      .hdma5_ctrl    (hdma5_ctrl),
      .hdma_src_high (hdma_src_high),
      .hdma_src_low  (hdma_src_low),
      .hdma_dst_high (hdma_dst_high),
      .hdma_dst_low  (hdma_dst_low),
      .vram_active   (vram_active),
      .vram_rd_addr  (vram_rd_addr),
      .vram_wr_addr  (vram_wr_addr),
      .vram_strobe_l (vram_strobe_l),
      .vram_busy     (vram_busy)
   );

   dma_port_arbiter u_arbiter (
      .oam_active    (oam_active),
      .oam_rd_addr   (oam_rd_addr),
      .oam_wr_addr   (oam_wr_addr),
      .oam_strobe_l  (oam_strobe_l),
      .vram_active   (vram_active),
      .vram_rd_addr  (vram_rd_addr),
      .vram_wr_addr  (vram_wr_addr),
      .vram_strobe_l (vram_strobe_l),
      .rdma_addr     (rdma_addr),
      .rdma_re_l     (rdma_re_l),
      .wdma_addr     (wdma_addr),
      .wdma_we_l     (wdma_we_l)
   );

endmodule

// File: verification/dma_controller_tb.sv
`timescale 1ns/1ps
`include "dma_consts.svh"

module dma_controller_tb;

   localparam int LINE_CYCLES = 456;   // one scanline between blanking pulses
   localparam int START_LIMIT = 8;     // cycles allowed before a burst begins
   localparam logic [`DMA_DATA_W-1:0] MODEL_XOR = 8'hA5;
   localparam int TEST_CYCLES = (`DMA_OAM_LEN + 40) + 2 * (4 * `DMA_BLOCK_LEN + 60)
                              + 2 * (3 * LINE_CYCLES + 40) + 120;
   localparam int WATCHDOG_CYCLES = TEST_CYCLES + 2500;

   logic                    clk;
   logic                    sync_reset;
   logic                    hblank;
   logic [`DMA_ADDR_W-1:0]  ioreg_addr;
   logic [`DMA_DATA_W-1:0]  ioreg_wdata;
   logic                    ioreg_we_l;
   logic                    ioreg_re_l;
   logic [`DMA_DATA_W-1:0]  ioreg_rdata;
   logic [`DMA_ADDR_W-1:0]  rdma_addr;
   logic                    rdma_re_l;
   logic [`DMA_DATA_W-1:0]  rdma_data;
   logic [`DMA_ADDR_W-1:0]  wdma_addr;
   logic                    wdma_we_l;
   logic [`DMA_DATA_W-1:0]  wdma_data;

   logic [31:0] lfsr_state = 32'ha46;
   int          value_errors = 0;
   int          sequence_errors = 0;

   dma_controller dut (
      .I_CLK        (clk),
      .I_SYNC_RESET (sync_reset),
      .I_HBLANK     (hblank),
      .*
   );

   assign rdma_data = rdma_addr[7:0] ^ MODEL_XOR;   // memory answers in the same cycle

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // galois lfsr, one step per bit taken
   function automatic logic [31:0] random_bits(input int width);
      logic [31:0] value;
      logic        out_bit;
      int          i;
      value = '0;
      for (i = 0; i < width; i++) begin
         out_bit    = lfsr_state[0];
         lfsr_state = (lfsr_state >> 1) ^ (out_bit ? 32'h80200003 : 32'h0);
         value      = {value[30:0], out_bit};
      end
      return value;
   endfunction

   function automatic logic [`DMA_ADDR_W-1:0] io_reg_addr(input int idx);
      return (idx == 0) ? `DMA_REG_OAM : `DMA_REG_HDMA1 + `DMA_ADDR_W'(idx - 1);
   endfunction

   task automatic cpu_write(input logic [`DMA_ADDR_W-1:0] addr, input logic [`DMA_DATA_W-1:0] data);
      @(posedge clk);
      ioreg_addr  <= addr;
      ioreg_wdata <= data;
      ioreg_we_l  <= 1'b0;
      @(posedge clk);
      ioreg_we_l  <= 1'b1;
   endtask

   task automatic cpu_read(input logic [`DMA_ADDR_W-1:0] addr, output logic [`DMA_DATA_W-1:0] data);
      @(posedge clk);
      ioreg_addr <= addr;
      ioreg_re_l <= 1'b0;
      @(negedge clk);
      data = ioreg_rdata;   // combinational read, settled by now
      @(posedge clk);
      ioreg_re_l <= 1'b1;
   endtask

   task automatic check_addr(input logic [`DMA_ADDR_W-1:0] got, input logic [`DMA_ADDR_W-1:0] exp,
                             input string what);
      if (got !== exp) begin
         $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
         value_errors++;
      end
   endtask

   task automatic check_byte(input logic [`DMA_DATA_W-1:0] got, input logic [`DMA_DATA_W-1:0] exp,
                             input string what);
      if (got !== exp) begin
         $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
         value_errors++;
      end
   endtask

   task automatic check_ctrl(input dma_pkg::hdma5_word_u got, input dma_pkg::hdma5_word_u exp,
                             input string what);
      if (got.raw !== exp.raw) begin
         $display("Error at %0t: %s is %h, expected %h", $time, what, got.raw, exp.raw);
         value_errors++;
      end
   endtask

   task automatic check_busy(input logic busy, input string what);
      dma_pkg::hdma5_word_u   got;
      dma_pkg::hdma5_word_u   exp;
      logic [`DMA_DATA_W-1:0] data;
      exp.raw              = '0;
      exp.ctrl.hblank_mode = busy;   // busy sits in bit 7
      cpu_read(`DMA_REG_HDMA5, data);
      got.raw = data;
      check_ctrl(got, exp, what);
   endtask

   task automatic check_quiet(input int cycles, input string what);
      int i;
      int busy_cycles;
      busy_cycles = 0;
      for (i = 0; i < cycles; i++) begin
         @(negedge clk);
         if (!wdma_we_l || !rdma_re_l) begin
            busy_cycles++;
         end
      end
      if (busy_cycles != 0) begin
         $display("%0d unexpected transfer cycles during %s", busy_cycles, what);
         sequence_errors++;
      end
   endtask

   // waits for the first strobe, then expects count back-to-back bytes
   task automatic check_burst(input logic [`DMA_ADDR_W-1:0] rd_base,
                              input logic [`DMA_ADDR_W-1:0] wr_base,
                              input int first, input int count, input string what);
      logic [`DMA_ADDR_W-1:0] exp_rd;
      int                     i;
      int                     waited;
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (wdma_we_l && waited < START_LIMIT);
      if (wdma_we_l) begin
         $display("The %s did not start within %0d cycles", what, START_LIMIT);
         sequence_errors++;
         return;
      end
      for (i = 0; i < count; i++) begin
         if (i > 0) begin
            @(negedge clk);
         end
         if (wdma_we_l || rdma_re_l) begin
            $display("The %s stopped after %0d of %0d bytes", what, i, count);
            sequence_errors++;
            return;
         end
         exp_rd = rd_base + `DMA_ADDR_W'(first + i);
         check_addr(rdma_addr, exp_rd, "read address");
         check_addr(wdma_addr, wr_base + `DMA_ADDR_W'(first + i), "write address");
         check_byte(wdma_data, exp_rd[7:0] ^ MODEL_XOR, "write data");
      end
      @(negedge clk);
      if (!wdma_we_l || !rdma_re_l) begin
         $display("The %s ran past its %0d bytes", what, count);
         sequence_errors++;
      end
   endtask

   // one scanline: a blanking pulse, the expected burst, then silence
   task automatic blank_line(input logic [`DMA_ADDR_W-1:0] rd_base,
                             input logic [`DMA_ADDR_W-1:0] wr_base,
                             input int first, input int count, input string what);
      @(posedge clk);
      hblank <= 1'b1;
      @(posedge clk);
      hblank <= 1'b0;
      if (count > 0) begin
         check_burst(rd_base, wr_base, first, count, what);
      end
      check_quiet(LINE_CYCLES - count - 8, what);
   endtask

   // random hdma1-4, returns the aligned bases
   task automatic program_vram(output logic [`DMA_ADDR_W-1:0] src_base,
                               output logic [`DMA_ADDR_W-1:0] dst_base);
      logic [`DMA_DATA_W-1:0] regs [4];
      int                     i;
      for (i = 0; i < 4; i++) begin
         regs[i] = 8'(random_bits(8));
         cpu_write(io_reg_addr(i + 1), regs[i]);
      end
      src_base = {regs[0], regs[1][7:4], 4'b0000};
      dst_base = {`DMA_VRAM_TOP, regs[2][4:0], regs[3][7:4], 4'b0000};
   endtask

   task automatic start_vram(input logic hblank_mode, input int blocks);
      dma_pkg::hdma5_word_u ctrl_byte;
      ctrl_byte.ctrl.hblank_mode = hblank_mode;
      ctrl_byte.ctrl.block_count = 7'(blocks);   // blocks minus one
      cpu_write(`DMA_REG_HDMA5, ctrl_byte.raw);
   endtask

   task automatic test_reset_state();
      logic [`DMA_DATA_W-1:0] data;
      int                     i;
      @(negedge clk);
      if (!rdma_re_l || !wdma_we_l) begin
         $display("A memory strobe is active right after reset");
         sequence_errors++;
      end
      check_addr(rdma_addr, '0, "read address after reset");
      check_addr(wdma_addr, '0, "write address after reset");
      check_busy(1'b0, "hdma5 status after reset");
      for (i = 0; i < 5; i++) begin
         cpu_read(io_reg_addr(i), data);
         check_byte(data, '0, "register after reset");
      end
   endtask

   task automatic test_oam_copy();
      logic [`DMA_DATA_W-1:0] page;
      page = 8'(random_bits(8));
      cpu_write(`DMA_REG_OAM, page);
      check_burst({page, 8'h00}, {`DMA_OAM_PAGE, 8'h00}, 0, `DMA_OAM_LEN, "oam dma");
   endtask

   task automatic test_general_copy();
      logic [`DMA_ADDR_W-1:0] src_base;
      logic [`DMA_ADDR_W-1:0] dst_base;
      int                     blocks;
      program_vram(src_base, dst_base);
      blocks = int'(random_bits(2));
      start_vram(1'b0, blocks);
      fork
         check_burst(src_base, dst_base, 0, (blocks + 1) * `DMA_BLOCK_LEN, "general dma");
         begin
            repeat (4) @(posedge clk);   // well inside even a 16 byte run
            check_busy(1'b1, "busy during general dma");
         end
      join
      check_busy(1'b0, "busy after general dma");
   endtask

   task automatic test_hblank_copy();
      logic [`DMA_ADDR_W-1:0] src_base;
      logic [`DMA_ADDR_W-1:0] dst_base;
      program_vram(src_base, dst_base);
      start_vram(1'b1, 1);
      check_quiet(20, "the wait for the first blanking edge");
      check_busy(1'b1, "busy while hblank dma waits");
      blank_line(src_base, dst_base, 0, `DMA_BLOCK_LEN, "hblank block 0");
      check_busy(1'b1, "busy between hblank blocks");
      blank_line(src_base, dst_base, `DMA_BLOCK_LEN, `DMA_BLOCK_LEN, "hblank block 1");
      blank_line(src_base, dst_base, 0, 0, "blanking after the last block");
      check_busy(1'b0, "busy after hblank dma");
   endtask

   task automatic test_hblank_cancel();
      logic [`DMA_ADDR_W-1:0] src_base;
      logic [`DMA_ADDR_W-1:0] dst_base;
      program_vram(src_base, dst_base);
      start_vram(1'b1, 3);
      blank_line(src_base, dst_base, 0, `DMA_BLOCK_LEN, "hblank block before the cancel");
      start_vram(1'b0, 0);   // mode bit low while paused
      check_quiet(20, "the cancel write");
      blank_line(src_base, dst_base, 0, 0, "blanking after the cancel");
      check_busy(1'b0, "busy after the cancel");
   endtask

   task automatic test_register_readback();
      logic [`DMA_DATA_W-1:0] written [5];
      logic [`DMA_DATA_W-1:0] data;
      int                     i;
      for (i = 0; i < 5; i++) begin
         written[i] = 8'(random_bits(8));
         cpu_write(io_reg_addr(i), written[i]);   // ff46 also kicks off an oam copy
      end
      for (i = 0; i < 5; i++) begin
         cpu_read(io_reg_addr(i), data);
         check_byte(data, written[i], "register read-back");
      end
   endtask

   initial begin
      sync_reset  <= 1'b1;
      hblank      <= 1'b0;
      ioreg_addr  <= '0;
      ioreg_wdata <= '0;
      ioreg_we_l  <= 1'b1;
      ioreg_re_l  <= 1'b1;
      repeat (3) @(posedge clk);
      sync_reset <= 1'b0;
      test_reset_state();
      test_oam_copy();
      test_general_copy();
      test_general_copy();
      test_hblank_copy();
      test_hblank_cancel();
      test_register_readback();
      $display("Done with %0d value errors and %0d sequence errors", value_errors,
               sequence_errors);
      if (value_errors == 0 && sequence_errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog ran out after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
      $display("Test FAILED");
      $finish;
   end

endmodule

// File: game_boy_dma.f
+incdir+source
source/dma_pkg.sv
source/dma_io_regs.sv
source/oam_dma_engine.sv
source/vram_dma_engine.sv
source/dma_port_arbiter.sv
source/dma_controller.sv
verification/dma_controller_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the dma testbench with verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module dma_controller_tb \
   -f game_boy_dma.f -o dma_sim

sim_output=$(./obj_dir/dma_sim)
echo "$sim_output"

if echo "$sim_output" | grep -q "^Test OK$"; then
   exit 0
else
   exit 1
fi
